// ==== Makefile ====
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module fetchCacheTb -f tb.f -o fetchCacheSim
	./obj_dir/fetchCacheSim | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== axiLiteMemModel.sv ====
`default_nettype none
`include "fetchCache_defines.svh"

module axiLiteMemModel (
   input  wire                       CLK,
   input  wire                       RESET,
   input  wire                       arvalid,
   output logic                      arready,
   input  wire [`AXI_ADDR_BITS-1:0]  araddr,
   output logic                      rvalid,
   input  wire                       rready,
   output logic [`AXI_DATA_BITS-1:0] rdata,
   output axiLitePkg::axiResp_e      rresp
);

   import axiLitePkg::*;

   int                        seed = 60295;
   logic [1:0]                arDelay;
   logic [1:0]                arCnt;
   logic [1:0]                rDelay;
   logic [1:0]                rCnt;
   logic                      rPending;
   logic [`AXI_ADDR_BITS-1:0] addrHeld;
   logic                      errPage;

   function automatic logic [1:0] drawDelay();
      logic [31:0] r;
      r = $random(seed);
      return r[1:0];
   endfunction

   assign arready = arvalid && !rPending && !rvalid && (arCnt == arDelay);
   assign errPage = (addrHeld[31:12] == 20'hE0000);  // Page at 0xE000_0000

   always @(posedge CLK or posedge RESET) begin
      if (RESET) begin
         arCnt    <= '0;
         arDelay  <= '0;
         rCnt     <= '0;
         rDelay   <= '0;
         rPending <= 1'b0;
         rvalid   <= 1'b0;
         rdata    <= '0;
         rresp    <= OKAY;
         addrHeld <= '0;
      end else begin
         if (arvalid && arready) begin
            arCnt    <= '0;
            arDelay  <= drawDelay();
            rCnt     <= '0;
            rPending <= 1'b1;
            addrHeld <= araddr;
         end else if (arvalid && arCnt != arDelay) begin
            arCnt <= arCnt + 1'b1;  // Address wait
         end
         if (rPending) begin
            if (rCnt == rDelay) begin
               rPending <= 1'b0;
               rvalid   <= 1'b1;
               rdata    <= {addrHeld[31:2], 2'b00} ^ 32'hA5A5_0000;
               rresp    <= errPage ? SLVERR : OKAY;
            end else begin
               rCnt <= rCnt + 1'b1;
            end
         end
         if (rvalid && rready) begin
            rvalid <= 1'b0;
            rDelay <= drawDelay();
         end
      end
   end

endmodule

`default_nettype wire

// ==== axiLitePkg.sv ====
`default_nettype none
`include "fetchCache_defines.svh"

package axiLitePkg;

   typedef enum logic [`AXI_RESP_BITS-1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } axiResp_e;

   // Instruction, secure, unprivileged
   localparam logic [`AXI_PROT_BITS-1:0] axiProtInstr = 3'b100;

endpackage

`default_nettype wire

// ==== fetchCacheLookup.sv ====
`default_nettype none
`include "fetchCache_defines.svh"

module fetchCacheLookup (
   input  wire                            CLK,
   input  wire                            RESET,
   input  wire                            reqValid,
   input  wire fetchCachePkg::fetchAddr_u reqAddr,
   input  wire                            refillDone,
   input  wire [`FC_DATA_BITS-1:0]        refillWord0,
   input  wire [`FC_DATA_BITS-1:0]        refillWord1,
   input  wire                            refillError,
   output logic                           reqReady,
   output logic                           respValid,
   output logic [`FC_DATA_BITS-1:0]       respData,
   output logic                           respError,
   output logic                           missStart,
   output fetchCachePkg::fetchAddr_u      missAddr,
   output logic [`FC_CNT_BITS-1:0]        hitCount,
   output logic [`FC_CNT_BITS-1:0]        missCount
);

   import fetchCachePkg::*;

   // Storage, indexed by way then set
   logic                     validArr [2][`FC_SETS];
   logic [`FC_TAG_BITS-1:0]  tagArr   [2][`FC_SETS];
   logic [`FC_DATA_BITS-1:0] dataArr  [2][`FC_SETS][2];
   logic [`FC_SETS-1:0]      olderWay;  // Way to replace next

   // Request stage
   logic       aValid;
   fetchAddr_u aAddr;

   // Compare stage
   logic                     bValid;
   fetchAddr_u               bAddr;
   logic [1:0]               bWayValid;
   logic [`FC_TAG_BITS-1:0]  bWayTag  [2];
   logic [`FC_DATA_BITS-1:0] bWayData [2][2];
   logic                     missIssued;
   logic                     bFilled;   // Refill block has arrived
   logic [`FC_DATA_BITS-1:0] fillData;
   logic                     fillError;

   logic [1:0] wayHit;
   logic       bHit;
   logic       hitWay;
   logic       stall;
   logic       advance;
   logic       victim;

   always_comb begin
      wayHit[0] = bWayValid[0] && (bWayTag[0] == bAddr.f.tag);
      wayHit[1] = bWayValid[1] && (bWayTag[1] == bAddr.f.tag);
   end

   assign bHit     = |wayHit;
   assign hitWay   = wayHit[1];
   assign stall    = bValid && !bHit && !bFilled;
   assign advance  = !stall;
   assign reqReady = advance;
   assign victim   = olderWay[bAddr.f.setIdx];  // Read live, hits may have moved it

   always_comb begin
      missAddr           = bAddr;
      missAddr.f.word    = 1'b0;  // Block base
      missAddr.f.byteOff = '0;
   end

   // Pipeline valids
   always_ff @(posedge CLK or posedge RESET) begin
      if (RESET) begin
         aValid <= 1'b0;
         bValid <= 1'b0;
      end else if (advance) begin
         aValid <= reqValid;
         bValid <= aValid;
      end
   end

   // Address capture and array read
   always_ff @(posedge CLK) begin
      if (advance) begin
         aAddr <= reqAddr;
         bAddr <= aAddr;
         for (int w = 0; w < 2; w++) begin
            bWayValid[w]   <= validArr[w][aAddr.f.setIdx];
            bWayTag[w]     <= tagArr[w][aAddr.f.setIdx];
            bWayData[w][0] <= dataArr[w][aAddr.f.setIdx][0];
            bWayData[w][1] <= dataArr[w][aAddr.f.setIdx][1];
         end
      end
   end

   // Miss sequencing
   always_ff @(posedge CLK or posedge RESET) begin
      if (RESET) begin
         missStart  <= 1'b0;
         missIssued <= 1'b0;
         bFilled    <= 1'b0;
         missCount  <= '0;
      end else begin
         missStart <= stall && !missIssued;
         if (advance) begin
            missIssued <= 1'b0;
            bFilled    <= 1'b0;
         end else begin
            if (!missIssued) begin
               missIssued <= 1'b1;
               missCount  <= missCount + 1'b1;
            end
            if (refillDone) begin
               bFilled <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge CLK) begin
      if (refillDone) begin
         fillData  <= refillError ? '0 : (bAddr.f.word ? refillWord1 : refillWord0);
         fillError <= refillError;
      end
   end

   // Valid and recency state
   always_ff @(posedge CLK or posedge RESET) begin
      if (RESET) begin
         for (int w = 0; w < 2; w++) begin
            for (int s = 0; s < `FC_SETS; s++) begin
               validArr[w][s] <= 1'b0;
            end
         end
         olderWay <= '0;
      end else if (refillDone && !refillError) begin
         validArr[victim][bAddr.f.setIdx] <= 1'b1;
         olderWay[bAddr.f.setIdx]         <= !victim;
      end else if (bValid && bHit) begin
         olderWay[bAddr.f.setIdx] <= !hitWay;
      end
   end

   always_ff @(posedge CLK) begin
      if (refillDone && !refillError) begin
         tagArr[victim][bAddr.f.setIdx]     <= bAddr.f.tag;
         dataArr[victim][bAddr.f.setIdx][0] <= refillWord0;
         dataArr[victim][bAddr.f.setIdx][1] <= refillWord1;
      end
   end

   // Response
   always_ff @(posedge CLK or posedge RESET) begin
      if (RESET) begin
         respValid <= 1'b0;
         hitCount  <= '0;
      end else begin
         respValid <= bValid && advance;
         if (bValid && bHit) begin
            hitCount <= hitCount + 1'b1;
         end
      end
   end

   always_ff @(posedge CLK) begin
      if (bValid && advance) begin
         if (bFilled) begin
            respData  <= fillData;
            respError <= fillError;
         end else begin
            respData  <= bWayData[hitWay][bAddr.f.word];
            respError <= 1'b0;
         end
      end
   end

   // A block is only ever installed in one way of its set
   aSingleWayHit: assert property (@(posedge CLK) disable iff (RESET)
      bValid |-> !(wayHit[0] && wayHit[1]))
      else $error("Fetch address hits in both ways");

   aRespNotWithMiss: assert property (@(posedge CLK) disable iff (RESET)
      !(respValid && missStart))
      else $error("Response and miss start in the same cycle");

   aRefillExpected: assert property (@(posedge CLK) disable iff (RESET)
      refillDone |-> (missIssued && !bFilled))
      else $error("Refill done without a pending miss");

endmodule

`default_nettype wire

// ==== fetchCachePkg.sv ====
`default_nettype none
`include "fetchCache_defines.svh"

package fetchCachePkg;

   // Field view of a fetch address
   typedef struct packed {
      logic [`FC_TAG_BITS-1:0]    tag;      // Bits 31 to 5
      logic [`FC_SET_BITS-1:0]    setIdx;   // Bits 4 to 3
      logic                       word;     // Word within the block
      logic [`FC_OFFSET_BITS-1:0] byteOff;  // Always zero for fetch
   } fetchAddrFields_t;

   // One address word, seen raw or by fields
   typedef union packed {
      logic [`FC_ADDR_BITS-1:0] raw;
      fetchAddrFields_t         f;
   } fetchAddr_u;

endpackage

`default_nettype wire

// ==== fetchCacheTb.sv ====
`default_nettype none
`include "fetchCache_defines.svh"

module fetchCacheTb;

   import axiLitePkg::*;

   localparam int resetCycles    = 8;
   localparam int totalRequests  = 63;
   localparam int worstRefill    = 24;  // Two slow beats plus pipeline
   localparam int watchdogCycles = resetCycles + totalRequests * worstRefill + 200;

   logic                      CLK;
   logic                      RESET;
   logic                      reqValid;
   logic [`FC_ADDR_BITS-1:0]  reqAddr;
   logic                      reqReady;
   logic                      respValid;
   logic [`FC_DATA_BITS-1:0]  respData;
   logic                      respError;
   logic [`FC_CNT_BITS-1:0]   hitCount;
   logic [`FC_CNT_BITS-1:0]   missCount;
   logic                      arvalid;
   logic                      arready;
   logic [`AXI_ADDR_BITS-1:0] araddr;
   logic [`AXI_PROT_BITS-1:0] arprot;
   logic                      rvalid;
   logic                      rready;
   logic [`AXI_DATA_BITS-1:0] rdata;
   axiResp_e                  rresp;

   int          seed;
   int          errorCount;
   int          checkCount;
   int unsigned cycle = 0;
   int unsigned lastAccept;
   string       testName;
   bit          timingCheck;
   bit          arBeat;  // Word of the next block read

   // Expected responses in request order
   logic [31:0] expAddr [$];
   logic [31:0] expData [$];
   logic        expErr  [$];
   int unsigned expEdge [$];

   // Recency model
   logic [28:0] mruBlk   [`FC_SETS];
   logic [28:0] lruBlk   [`FC_SETS];
   logic        mruValid [`FC_SETS];
   logic        lruValid [`FC_SETS];
   int          expHits;
   int          expMisses;

   fetchCacheTop UUT (.*);

   axiLiteMemModel mem (.*);

   initial begin
      CLK = 1'b0;
      forever #10 CLK = ~CLK;
   end

   always @(posedge CLK) cycle <= cycle + 1;

   function automatic logic inErrorPage(input logic [31:0] addr);
      return addr[31:12] == 20'hE0000;
   endfunction

   task automatic expectEqual(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      checkCount++;
      assert (actual === expected) else begin
         $display("CHECK FAILED %s %s: expected 0x%08h, actual 0x%08h",
                  testName, what, expected, actual);
         errorCount++;
      end
   endtask

   task automatic updateRecency(input logic [31:0] addr);
      logic [28:0] blk;
      logic [1:0]  s;
      blk = addr[31:3];
      s   = addr[4:3];
      if (mruValid[s] && mruBlk[s] == blk) begin
         expHits++;
      end else if (lruValid[s] && lruBlk[s] == blk) begin
         expHits++;
         lruBlk[s] = mruBlk[s];  // Swap ages
         mruBlk[s] = blk;
      end else begin
         expMisses++;
         if (!inErrorPage(addr)) begin
            lruBlk[s]   = mruBlk[s];
            lruValid[s] = mruValid[s];
            mruBlk[s]   = blk;
            mruValid[s] = 1'b1;
         end
      end
   endtask

   // Called on a falling edge, returns on the falling edge after acceptance
   task automatic issueFetch(input logic [31:0] addr);
      reqValid = 1'b1;
      reqAddr  = addr;
      while (!reqReady) @(negedge CLK);
      lastAccept = cycle + 1;
      updateRecency(addr);
      expAddr.push_back(addr);
      expData.push_back(inErrorPage(addr) ? 32'h0 : (addr ^ 32'hA5A5_0000));
      expErr.push_back(inErrorPage(addr));
      expEdge.push_back(lastAccept);
      @(negedge CLK);
      reqValid = 1'b0;
   endtask

   task automatic drainResponses();
      while (expData.size() != 0) @(negedge CLK);
   endtask

   task automatic fetchAndCount(input logic [31:0] addr, input bit expectHit);
      logic [`FC_CNT_BITS-1:0] hitsBefore;
      logic [`FC_CNT_BITS-1:0] missesBefore;
      hitsBefore   = hitCount;
      missesBefore = missCount;
      issueFetch(addr);
      drainResponses();
      expectEqual($sformatf("hit step %08h", addr), hitsBefore + expectHit, hitCount);
      expectEqual($sformatf("miss step %08h", addr), missesBefore + !expectHit, missCount);
   endtask

   task automatic matchCounters();
      expectEqual("hitCount", expHits, hitCount);
      expectEqual("missCount", expMisses, missCount);
   endtask

   task automatic expectIdle();
      expectEqual("respValid", 0, respValid);
      expectEqual("arvalid", 0, arvalid);
      expectEqual("reqReady", 1, reqReady);
      expectEqual("hitCount", 0, hitCount);
      expectEqual("missCount", 0, missCount);
   endtask

   task automatic resetState();
      testName = "resetState";
      RESET = 1'b1;
      repeat (resetCycles / 2) @(negedge CLK);
      expectIdle();
      repeat (resetCycles / 2) @(negedge CLK);
      RESET = 1'b0;
      @(negedge CLK);
      expectIdle();
   endtask

   task automatic coldMissThenHit();
      testName = "coldMissThenHit";
      fetchAndCount(32'h0000_1000, 1'b0);
      expectEqual("missCount", 1, missCount);
      fetchAndCount(32'h0000_1004, 1'b1);
      expectEqual("hitCount", 1, hitCount);
      matchCounters();
   endtask

   task automatic lruReplacement();
      testName = "lruReplacement";
      fetchAndCount(32'h0000_2008, 1'b0);  // A
      fetchAndCount(32'h0000_3008, 1'b0);  // B
      fetchAndCount(32'h0000_2008, 1'b1);  // B becomes older
      fetchAndCount(32'h0000_4008, 1'b0);  // C evicts B
      fetchAndCount(32'h0000_200C, 1'b1);
      fetchAndCount(32'h0000_3008, 1'b0);
      matchCounters();
   endtask

   task automatic pipelinedHits();
      int unsigned             prevAccept;
      logic [`FC_CNT_BITS-1:0] hitsBefore;
      testName = "pipelinedHits";
      for (int s = 0; s < `FC_SETS; s++) begin
         fetchAndCount(32'h0001_0000 + s * 8, 1'b0);
      end
      hitsBefore  = hitCount;
      timingCheck = 1'b1;
      for (int n = 0; n < 8; n++) begin
         issueFetch(32'h0001_0000 + (n % 4) * 8 + (n / 4) * 4);
         if (n > 0) begin
            expectEqual("accept cycle", prevAccept + 1, lastAccept);
         end
         prevAccept = lastAccept;
      end
      drainResponses();
      timingCheck = 1'b0;
      expectEqual("hits", hitsBefore + 8, hitCount);
      matchCounters();
   endtask

   task automatic randomBusDelays();
      logic [31:0]             r;
      logic [`FC_CNT_BITS-1:0] hitsBefore;
      logic [`FC_CNT_BITS-1:0] missesBefore;
      testName     = "randomBusDelays";
      hitsBefore   = hitCount;
      missesBefore = missCount;
      for (int n = 0; n < 40; n++) begin
         r = $random(seed);
         // Four tags in each of sets 2 and 3, either word
         issueFetch({24'h000200, 1'b0, r[2:1], 1'b1, r[0], r[3], 2'b00});
      end
      drainResponses();
      expectEqual("hits plus misses", 40,
                  (hitCount - hitsBefore) + (missCount - missesBefore));
      matchCounters();
   endtask

   task automatic errorResponse();
      testName = "errorResponse";
      fetchAndCount(32'hE000_0010, 1'b0);
      fetchAndCount(32'hE000_0010, 1'b0);  // Not installed
      fetchAndCount(32'h0000_5010, 1'b0);
      matchCounters();
   endtask

   // Response monitor
   always @(negedge CLK) begin : monitor
      logic [31:0] wantAddr;
      logic [31:0] wantData;
      logic        wantErr;
      int unsigned wantEdge;
      if (!RESET && respValid) begin
         assert (expData.size() != 0) else begin
            $display("ERROR in %s: response arrived with no request outstanding", testName);
            errorCount++;
         end
         if (expData.size() != 0) begin
            wantAddr = expAddr.pop_front();
            wantData = expData.pop_front();
            wantErr  = expErr.pop_front();
            wantEdge = expEdge.pop_front();
            expectEqual($sformatf("respData %08h", wantAddr), wantData, respData);
            expectEqual($sformatf("respError %08h", wantAddr), wantErr, respError);
            if (timingCheck) begin
               expectEqual("response cycle", wantEdge + 2, cycle);
            end
         end
      end
      if (!RESET && arvalid && arready) begin
         expectEqual("arprot", 3'b100, arprot);  // Instruction access
         assert (expAddr.size() != 0) else begin
            $display("ERROR in %s: bus read issued with no fetch outstanding", testName);
            errorCount++;
         end
         if (expAddr.size() != 0) begin
            expectEqual("araddr", {expAddr[0][31:3], arBeat, 2'b00}, araddr);
         end
         arBeat = !arBeat;
      end
   end

   initial begin : watchdog
      repeat (watchdogCycles) @(posedge CLK);
      $display("Timeout: the run did not end within %0d cycles", watchdogCycles);
      $display("Finished with errors");
      $finish;
   end

   initial begin
      RESET       = 1'b1;
      reqValid    = 1'b0;
      reqAddr     = '0;
      seed        = 60295;
      errorCount  = 0;
      checkCount  = 0;
      timingCheck = 1'b0;
      arBeat      = 1'b0;
      expHits     = 0;
      expMisses   = 0;
      for (int s = 0; s < `FC_SETS; s++) begin
         mruBlk[s]   = '0;
         lruBlk[s]   = '0;
         mruValid[s] = 1'b0;
         lruValid[s] = 1'b0;
      end
      resetState();
      coldMissThenHit();
      lruReplacement();
      pipelinedHits();
      randomBusDelays();
      errorResponse();
      $display("Checks: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== fetchCacheTop.sv ====
`default_nettype none
`include "fetchCache_defines.svh"

module fetchCacheTop (
   input  wire                        CLK,
   input  wire                        RESET,
   input  wire                        reqValid,
   input  wire [`FC_ADDR_BITS-1:0]    reqAddr,
   output logic                       reqReady,
   output logic                       respValid,
   output logic [`FC_DATA_BITS-1:0]   respData,
   output logic                       respError,
   output logic [`FC_CNT_BITS-1:0]    hitCount,
   output logic [`FC_CNT_BITS-1:0]    missCount,
   output logic                       arvalid,
   input  wire                        arready,
   output logic [`AXI_ADDR_BITS-1:0]  araddr,
   output logic [`AXI_PROT_BITS-1:0]  arprot,
   input  wire                        rvalid,
   output logic                       rready,
   input  wire [`AXI_DATA_BITS-1:0]   rdata,
   input  wire axiLitePkg::axiResp_e  rresp
);

   import fetchCachePkg::*;
   import axiLitePkg::*;

   logic                     missStart;
   fetchAddr_u               missAddr;
   logic                     refillDone;
   logic [`FC_DATA_BITS-1:0] refillWord0;
   logic [`FC_DATA_BITS-1:0] refillWord1;
   logic                     refillError;

   assign arprot = axiProtInstr;

   fetchCacheLookup lookup (
      .CLK         (CLK),
      .RESET       (RESET),
      .reqValid    (reqValid),
      .reqAddr     (reqAddr),
      .refillDone  (refillDone),
      .refillWord0 (refillWord0),
      .refillWord1 (refillWord1),
      .refillError (refillError),
      .reqReady    (reqReady),
      .respValid   (respValid),
      .respData    (respData),
      .respError   (respError),
      .missStart   (missStart),
      .missAddr    (missAddr),
      .hitCount    (hitCount),
      .missCount   (missCount)
   );

   fetchRefill refill (
      .CLK         (CLK),
      .RESET       (RESET),
      .missStart   (missStart),
      .missAddr    (missAddr),
      .arready     (arready),
      .rvalid      (rvalid),
      .rdata       (rdata),
      .rresp       (rresp),
      .arvalid     (arvalid),
      .araddr      (araddr),
      .rready      (rready),
      .refillDone  (refillDone),
      .refillWord0 (refillWord0),
      .refillWord1 (refillWord1),
      .refillError (refillError)
   );

endmodule

`default_nettype wire

// ==== fetchCache_defines.svh ====
`ifndef FETCH_CACHE_DEFINES_SVH
`define FETCH_CACHE_DEFINES_SVH

// Cache geometry
`define FC_ADDR_BITS   32
`define FC_DATA_BITS   32
`define FC_TAG_BITS    27
`define FC_SET_BITS    2
`define FC_SETS        4
`define FC_OFFSET_BITS 2

// Statistics counters
`define FC_CNT_BITS    20

// AXI4-Lite read channel widths
`define AXI_ADDR_BITS  32
`define AXI_DATA_BITS  32
`define AXI_RESP_BITS  2
`define AXI_PROT_BITS  3

`endif

// ==== fetchRefill.sv ====
`default_nettype none
`include "fetchCache_defines.svh"

module fetchRefill (
   input  wire                            CLK,
   input  wire                            RESET,
   input  wire                            missStart,
   input  wire fetchCachePkg::fetchAddr_u missAddr,
   input  wire                            arready,
   input  wire                            rvalid,
   input  wire [`AXI_DATA_BITS-1:0]       rdata,
   input  wire axiLitePkg::axiResp_e      rresp,
   output logic                           arvalid,
   output logic [`AXI_ADDR_BITS-1:0]      araddr,
   output logic                           rready,
   output logic                           refillDone,
   output logic [`FC_DATA_BITS-1:0]       refillWord0,
   output logic [`FC_DATA_BITS-1:0]       refillWord1,
   output logic                           refillError
);

   import fetchCachePkg::*;
   import axiLitePkg::*;

   localparam logic [2:0] sIdle  = 3'd0;
   localparam logic [2:0] sAddr0 = 3'd1;
   localparam logic [2:0] sData0 = 3'd2;
   localparam logic [2:0] sAddr1 = 3'd3;
   localparam logic [2:0] sData1 = 3'd4;
   localparam logic [2:0] sDone  = 3'd5;

   logic [2:0] state;
   fetchAddr_u blockAddr;
   fetchAddr_u wordAddr;

   always_ff @(posedge CLK or posedge RESET) begin
      if (RESET) begin
         state <= sIdle;
      end else begin
         case (state)
            sIdle: begin
               if (missStart) begin
                  state <= sAddr0;
               end
            end
            sAddr0: begin
               if (arready) begin
                  state <= sData0;
               end
            end
            sData0: begin
               if (rvalid) begin
                  state <= sAddr1;
               end
            end
            sAddr1: begin
               if (arready) begin
                  state <= sData1;
               end
            end
            sData1: begin
               if (rvalid) begin
                  state <= sDone;
               end
            end
            default: begin
               state <= sIdle;  // Done lasts one cycle
            end
         endcase
      end
   end

   always_ff @(posedge CLK) begin
      if (state == sIdle && missStart) begin
         blockAddr   <= missAddr;
         refillError <= 1'b0;
      end else if (rready && rvalid && rresp != OKAY) begin
         refillError <= 1'b1;  // Sticky across both beats
      end
      if (state == sData0 && rvalid) begin
         refillWord0 <= rdata;
      end
      if (state == sData1 && rvalid) begin
         refillWord1 <= rdata;
      end
   end

   always_comb begin
      wordAddr           = blockAddr;
      wordAddr.f.word    = (state == sAddr1);
      wordAddr.f.byteOff = '0;
   end

   assign araddr     = wordAddr.raw;
   assign arvalid    = (state == sAddr0) || (state == sAddr1);
   assign rready     = (state == sData0) || (state == sData1);
   assign refillDone = (state == sDone);

   aMissWhileIdle: assert property (@(posedge CLK) disable iff (RESET)
      missStart |-> (state == sIdle))
      else $error("Miss start while a refill is running");

   aAddrHeld: assert property (@(posedge CLK) disable iff (RESET)
      (arvalid && !arready) |=> (arvalid && $stable(araddr)))
      else $error("Read address changed before arready");

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
fetchCachePkg.sv
axiLitePkg.sv
fetchCacheLookup.sv
fetchRefill.sv
fetchCacheTop.sv
axiLiteMemModel.sv
fetchCacheTb.sv
